// ==== Bender.yml ====
package:
  name: rd_order_monitor

sources:
  - rtl/rd_order_pkg.sv
  - rtl/ar_issue_log.sv
  - rtl/slv_beat_credit.sv
  - rtl/rsp_order_check.sv
  - rtl/order_check_ctrl.sv
  - rtl/rd_order_monitor.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_rd_order_monitor.sv

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset source, reset is held again for ResetCycles on each request
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real         Period      = 40.0,
  parameter int unsigned ResetCycles = 16
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2.0) clk_o = ~clk_o;
  end

  // release shortly after an edge, assert at once on request
  initial begin
    arst_n_o = 1'b0;
    forever begin
      repeat (ResetCycles) @(posedge clk_o);
      #2 arst_n_o = 1'b1;
      @(posedge rst_req_i);
      arst_n_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_rd_order_monitor.sv ====
// testbench for the read-order monitor that runs legal and faulty read scenarios against a reference
`timescale 1ns/1ps
`default_nettype none

module tb_rd_order_monitor;

  localparam int unsigned NumSlaves     = 2;
  localparam int unsigned FifoDepth     = 4;
  localparam int unsigned ResetCycles   = 16;
  localparam int unsigned MaxGap        = 4;
  localparam int unsigned MaxStall      = 3;
  localparam int unsigned RandBatches   = 8;
  localparam int unsigned MaxBatchReads = 4;
  localparam int unsigned MaxBurst      = 4;
  localparam int unsigned NumScenarios  = 7;
  // worst case event counts and cycles per event
  localparam int unsigned RandEvents    = RandBatches * MaxBatchReads * (1 + 2 * MaxBurst);
  localparam int unsigned ErrEvents     = (NumScenarios - 1) * 8;
  localparam int unsigned EventCycles   = MaxGap + MaxStall;
  localparam int unsigned TestCycles    = (RandEvents + ErrEvents) * EventCycles
                                          + NumScenarios * (ResetCycles + 8);
  localparam int unsigned CycleLimit    = 2 * TestCycles;

  typedef enum logic [1:0] {
    EV_AR,
    EV_SLV_R,
    EV_MST_R
  } ev_kind_e;

  typedef struct packed {
    ev_kind_e                           kind;
    rd_order_pkg::id_t                  id;
    logic [rd_order_pkg::AddrWidth-1:0] addr;
    rd_order_pkg::len_t                 len;
    rd_order_pkg::slv_idx_t             slv;
    logic                               last;
  } ev_t;

  logic                                  clk;
  logic                                  arst_n;
  logic                                  rst_req;
  rd_order_pkg::ar_beat_t                mst_ar;
  rd_order_pkg::r_beat_t                 mst_r;
  rd_order_pkg::r_beat_t [NumSlaves-1:0] slv_r;
  logic                                  err;
  rd_order_pkg::err_code_e               err_code;
  logic                                  idle;

  logic [31:0]             lcg_state = 32'hb6be_4103;
  int unsigned             cycle_cnt = 0;
  ev_t                     scen_q[$];
  rd_order_pkg::err_code_e exp_code;
  event                    scen_done;
  event                    check_done;

  tb_clk_gen #(
    .Period      (40.0),
    .ResetCycles (ResetCycles)
  ) clk_gen_i (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .arst_n_o  (arst_n)
  );

  rd_order_monitor #(
    .NumSlaves (NumSlaves),
    .FifoDepth (FifoDepth)
  ) dut_i (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .mst_ar_i   (mst_ar),
    .mst_r_i    (mst_r),
    .slv_r_i    (slv_r),
    .err_o      (err),
    .err_code_o (err_code),
    .idle_o     (idle)
  );

  function automatic int unsigned next_rand(input int unsigned bound);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 8) % bound;
  endfunction

  // expected first error of an event list with one handshake per event
  function automatic rd_order_pkg::err_code_e expect_code(input ev_t evs[$]);
    rd_order_pkg::issue_t log_q [rd_order_pkg::NumIds][$];
    rd_order_pkg::id_t    tag_q [NumSlaves][$];
    int unsigned          credit [NumSlaves][rd_order_pkg::NumIds];
    int unsigned          beats [rd_order_pkg::NumIds];
    int unsigned          region;
    rd_order_pkg::issue_t head;
    rd_order_pkg::id_t    id;
    credit = '{default: 0};
    beats  = '{default: 0};
    foreach (evs[k]) begin
      id = evs[k].id;
      case (evs[k].kind)
        EV_AR: begin
          region = evs[k].addr / rd_order_pkg::RegionSize;
          if (region >= NumSlaves) return rd_order_pkg::ERR_DECODE;
          if (log_q[id].size() == FifoDepth) return rd_order_pkg::ERR_OVERFLOW;
          log_q[id].push_back('{slv: rd_order_pkg::slv_idx_t'(region), len: evs[k].len});
          if (tag_q[region].size() == FifoDepth) return rd_order_pkg::ERR_OVERFLOW;
          tag_q[region].push_back(id);
        end
        EV_SLV_R: begin
          if (tag_q[evs[k].slv].size() == 0) return rd_order_pkg::ERR_SLV_UNEXP;
          credit[evs[k].slv][tag_q[evs[k].slv][0]]++;
          if (evs[k].last) void'(tag_q[evs[k].slv].pop_front());
        end
        default: begin
          if (log_q[id].size() == 0) return rd_order_pkg::ERR_NO_ISSUE;
          head = log_q[id][0];
          if (credit[head.slv][id] == 0) return rd_order_pkg::ERR_ORDER;
          credit[head.slv][id]--;
          // last belongs on beat len+1 exactly
          if (evs[k].last != (beats[id] == head.len)) return rd_order_pkg::ERR_LEN;
          if (evs[k].last) begin
            beats[id] = 0;
            void'(log_q[id].pop_front());
          end else begin
            beats[id]++;
          end
        end
      endcase
    end
    return rd_order_pkg::ERR_NONE;
  endfunction

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_err(input string name, input rd_order_pkg::err_code_e exp,
                           input rd_order_pkg::err_code_e act);
    if (act !== exp) begin
      report_fail($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_fail($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_inputs();
    mst_ar = '0;
    mst_r  = '0;
    slv_r  = '0;
  endtask

  task automatic issue_read(input rd_order_pkg::id_t id,
                            input logic [rd_order_pkg::AddrWidth-1:0] addr,
                            input rd_order_pkg::len_t len);
    scen_q.push_back('{kind: EV_AR, id: id, addr: addr, len: len, slv: '0, last: 1'b0});
  endtask

  task automatic serve_beat(input rd_order_pkg::slv_idx_t slv, input logic last);
    scen_q.push_back('{kind: EV_SLV_R, id: '0, addr: '0, len: '0, slv: slv, last: last});
  endtask

  task automatic return_beat(input rd_order_pkg::id_t id, input logic last);
    scen_q.push_back('{kind: EV_MST_R, id: id, addr: '0, len: '0, slv: '0, last: last});
  endtask

  task automatic apply_channel(input ev_t ev, input logic valid, input logic ready);
    case (ev.kind)
      EV_AR: mst_ar = '{valid: valid, ready: ready, id: ev.id, addr: ev.addr, len: ev.len};
      EV_SLV_R: slv_r[ev.slv] = '{valid: valid, ready: ready, id: ev.id, last: ev.last};
      default: mst_r = '{valid: valid, ready: ready, id: ev.id, last: ev.last};
    endcase
  endtask

  // idle gap, then back-pressure, then one handshake
  task automatic drive_event(input ev_t ev);
    int unsigned gap;
    int unsigned stall;
    gap   = next_rand(MaxGap);
    stall = next_rand(MaxStall);
    repeat (gap) wait_cycle();
    repeat (stall) begin
      apply_channel(ev, 1'b1, 1'b0);
      wait_cycle();
    end
    apply_channel(ev, 1'b1, 1'b1);
    wait_cycle();
    clear_inputs();
  endtask

  task automatic reset_dut();
    if (arst_n === 1'b1) begin
      rst_req = 1'b1;
      wait (arst_n === 1'b0);
      rst_req = 1'b0;
    end
    wait (arst_n === 1'b1);
    wait_cycle();
  endtask

  // batches of reads where each slave serves in arrival order
  task automatic build_random_traffic();
    rd_order_pkg::id_t      ids [MaxBatchReads];
    rd_order_pkg::slv_idx_t slvs [MaxBatchReads];
    rd_order_pkg::len_t     lens [MaxBatchReads];
    int unsigned            sent [MaxBatchReads];
    int unsigned            n;
    int unsigned            pending;
    int unsigned            s;
    for (int b = 0; b < RandBatches; b++) begin
      n       = 1 + next_rand(MaxBatchReads);
      pending = 0;
      for (int r = 0; r < n; r++) begin
        ids[r]  = rd_order_pkg::id_t'(next_rand(rd_order_pkg::NumIds));
        slvs[r] = rd_order_pkg::slv_idx_t'(next_rand(NumSlaves));
        lens[r] = rd_order_pkg::len_t'(next_rand(MaxBurst));
        sent[r] = 0;
        pending += lens[r] + 1;
        issue_read(ids[r], 32'(slvs[r]) * rd_order_pkg::RegionSize
                   + next_rand(rd_order_pkg::RegionSize), lens[r]);
      end
      while (pending != 0) begin
        s = next_rand(NumSlaves);
        for (int r = 0; r < n; r++) begin
          if (slvs[r] == s && sent[r] <= lens[r]) begin
            serve_beat(slvs[r], sent[r] == lens[r]);
            sent[r]++;
            pending--;
            break;
          end
        end
      end
      for (int r = 0; r < n; r++) begin
        for (int k = 0; k <= lens[r]; k++) begin
          return_beat(ids[r], k == lens[r]);
        end
      end
    end
  endtask

  task automatic run_scenario(input string name);
    reset_dut();
    check_bit("err_o", 1'b0, err);
    check_err("err_code_o", rd_order_pkg::ERR_NONE, err_code);
    check_bit("idle_o", 1'b1, idle);
    exp_code = expect_code(scen_q);
    $display("scenario %s, %0d events, expecting %s", name, scen_q.size(), exp_code.name());
    foreach (scen_q[k]) begin
      drive_event(scen_q[k]);
    end
    -> scen_done;
    @(check_done);
    scen_q.delete();
  endtask

  // legal runs go idle on the edge after the final beat retires
  always begin
    @(scen_done);
    if (exp_code == rd_order_pkg::ERR_NONE) begin
      check_bit("idle_o", 1'b0, idle);
      wait_cycle();
      check_bit("idle_o", 1'b1, idle);
      check_bit("err_o", 1'b0, err);
      check_err("err_code_o", exp_code, err_code);
    end else begin
      wait_cycle();
      while (err !== 1'b1) wait_cycle();
      wait_cycle();
      check_bit("err_o", 1'b1, err);
      check_err("err_code_o", exp_code, err_code);
    end
    -> check_done;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == CycleLimit) begin
      report_fail($sformatf("timeout, no result after %0d cycles", CycleLimit));
    end
  end

  initial begin
    rst_req = 1'b0;
    clear_inputs();

    build_random_traffic();
    run_scenario("random legal traffic");

    issue_read(2'd1, 32'h0000_0040, 8'd0);
    issue_read(2'd1, rd_order_pkg::RegionSize + 32'h80, 8'd0);
    serve_beat(2'd1, 1'b1);
    return_beat(2'd1, 1'b1);
    run_scenario("second slave first");

    issue_read(2'd0, NumSlaves * rd_order_pkg::RegionSize + 32'h10, 8'd1);
    run_scenario("unmapped address");

    issue_read(2'd2, 32'h0000_0100, 8'd3);
    for (int k = 0; k < 4; k++) begin
      serve_beat(2'd0, k == 3);
    end
    return_beat(2'd2, 1'b0);
    return_beat(2'd2, 1'b0);
    return_beat(2'd2, 1'b1);
    run_scenario("early last");

    return_beat(2'd3, 1'b1);
    run_scenario("master beat without read");

    serve_beat(2'd1, 1'b1);
    run_scenario("slave beat without read");

    // fifth read on one ID, then errors that must not replace the code
    for (int k = 0; k < 5; k++) begin
      issue_read(2'd0, (k % 2) * rd_order_pkg::RegionSize + 16 * k, 8'd1);
    end
    return_beat(2'd3, 1'b1);
    issue_read(2'd1, 32'h0010_0000, 8'd0);
    run_scenario("log overflow");

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/rd_order_pkg.sv
rtl/ar_issue_log.sv
rtl/slv_beat_credit.sv
rtl/rsp_order_check.sv
rtl/order_check_ctrl.sv
rtl/rd_order_monitor.sv
dv/tb_clk_gen.sv
dv/tb_rd_order_monitor.sv

// ==== rtl/ar_issue_log.sv ====
// decodes accepted master read addresses and keeps one FIFO of target slave and length per ID
`timescale 1ns/1ps
`default_nettype none

module ar_issue_log #(
  parameter int unsigned NumSlaves = 2,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  rd_order_pkg::ar_beat_t                          ar_i,
  input  logic                                            pop_i,
  input  rd_order_pkg::id_t                               pop_id_i,
  output rd_order_pkg::issue_t [rd_order_pkg::NumIds-1:0] head_o,
  output logic [rd_order_pkg::NumIds-1:0]                 log_empty_o,
  output logic                                            push_o,
  output rd_order_pkg::id_t                               push_id_o,
  output rd_order_pkg::slv_idx_t                          push_slv_o,
  output logic                                            busy_o,
  output rd_order_pkg::err_flags_t                        err_o
);

  localparam int unsigned NumIds   = rd_order_pkg::NumIds;
  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);
  localparam int unsigned RegWidth = rd_order_pkg::AddrWidth - rd_order_pkg::RegionBits;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  logic [RegWidth-1:0] region;
  logic [NumIds-1:0]   full;
  logic                handshake;
  logic                mapped;
  logic                id_full;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // region index is the address above the region offset
  assign handshake = ar_i.valid & ar_i.ready;
  assign region    = ar_i.addr[rd_order_pkg::AddrWidth-1:rd_order_pkg::RegionBits];
  assign mapped    = region < RegWidth'(NumSlaves);
  assign id_full   = full[ar_i.id];

  assign push_o     = handshake & mapped & ~id_full;
  assign push_id_o  = ar_i.id;
  assign push_slv_o = region[rd_order_pkg::SlvIdxWidth-1:0];

  always_comb begin
    err_o          = '0;
    err_o.decode   = handshake & ~mapped;
    err_o.overflow = handshake & mapped & id_full;
  end

  for (genvar i = 0; i < NumIds; i++) begin : gen_id
    rd_order_pkg::issue_t mem_q [FifoDepth];
    ptr_t                 wr_ptr_q;
    ptr_t                 rd_ptr_q;
    cnt_t                 cnt_q;
    logic                 push_here;
    logic                 pop_here;

    assign push_here = push_o && (ar_i.id == rd_order_pkg::id_t'(i));
    assign pop_here  = pop_i && (pop_id_i == rd_order_pkg::id_t'(i));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push_here) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_here) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        cnt_q <= cnt_q + cnt_t'(push_here) - cnt_t'(pop_here);
      end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
      if (push_here) begin
        mem_q[wr_ptr_q] <= '{slv: push_slv_o, len: ar_i.len};
      end
    end

    assign head_o[i]      = mem_q[rd_ptr_q];
    assign log_empty_o[i] = (cnt_q == '0);
    assign full[i]        = (cnt_q == cnt_t'(FifoDepth));
  end

  assign busy_o = ~&log_empty_o;

  // response checker must only retire reads that were logged
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop_i |-> !log_empty_o[pop_id_i]
  );

endmodule

`default_nettype wire

// ==== rtl/order_check_ctrl.sv ====
// monitor controller, latches the first error code by priority and registers the idle flag
`timescale 1ns/1ps
`default_nettype none

module order_check_ctrl #(
  parameter int unsigned NumBusy = 3
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  rd_order_pkg::err_flags_t  flags_i,
  input  logic [NumBusy-1:0]        busy_i,
  output logic                      err_o,
  output rd_order_pkg::err_code_e   err_code_o,
  output logic                      idle_o
);

  rd_order_pkg::ctrl_state_e state_q;
  rd_order_pkg::err_code_e   code_q;
  rd_order_pkg::err_code_e   code_d;
  logic                      idle_q;

  // fixed priority, same order as the code enum
  always_comb begin
    code_d = rd_order_pkg::ERR_NONE;
    if (flags_i.decode) begin
      code_d = rd_order_pkg::ERR_DECODE;
    end else if (flags_i.overflow) begin
      code_d = rd_order_pkg::ERR_OVERFLOW;
    end else if (flags_i.no_issue) begin
      code_d = rd_order_pkg::ERR_NO_ISSUE;
    end else if (flags_i.order) begin
      code_d = rd_order_pkg::ERR_ORDER;
    end else if (flags_i.length) begin
      code_d = rd_order_pkg::ERR_LEN;
    end else if (flags_i.slv_unexp) begin
      code_d = rd_order_pkg::ERR_SLV_UNEXP;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= rd_order_pkg::ST_RUN;
      code_q  <= rd_order_pkg::ERR_NONE;
      idle_q  <= 1'b1;
    end else begin
      idle_q <= ~|busy_i;
      case (state_q)
        rd_order_pkg::ST_RUN: begin
          if (code_d != rd_order_pkg::ERR_NONE) begin
            state_q <= rd_order_pkg::ST_FAIL;
            code_q  <= code_d;
          end
        end
        // held until reset
        default: begin
          state_q <= rd_order_pkg::ST_FAIL;
        end
      endcase
    end
  end

  assign err_o      = (state_q == rd_order_pkg::ST_FAIL);
  assign err_code_o = code_q;
  assign idle_o     = idle_q;

  a_code_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    state_q == rd_order_pkg::ST_FAIL |=> code_q == $past(code_q)
  );

endmodule

`default_nettype wire

// ==== rtl/rd_order_monitor.sv ====
// top level of the read-order monitor, snoops one master port and NumSlaves slave ports
`timescale 1ns/1ps
`default_nettype none

module rd_order_monitor #(
  parameter int unsigned NumSlaves = 2,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  rd_order_pkg::ar_beat_t                mst_ar_i,
  input  rd_order_pkg::r_beat_t                 mst_r_i,
  input  rd_order_pkg::r_beat_t [NumSlaves-1:0] slv_r_i,
  output logic                                  err_o,
  output rd_order_pkg::err_code_e               err_code_o,
  output logic                                  idle_o
);

  localparam int unsigned NumIds = rd_order_pkg::NumIds;

  rd_order_pkg::issue_t [NumIds-1:0] head;
  logic [NumIds-1:0]                 log_empty;
  logic [NumSlaves-1:0][NumIds-1:0]  credit_avail;
  logic                              pop;
  rd_order_pkg::id_t                 pop_id;
  logic                              push;
  rd_order_pkg::id_t                 push_id;
  rd_order_pkg::slv_idx_t            push_slv;
  logic                              take;
  rd_order_pkg::id_t                 take_id;
  rd_order_pkg::slv_idx_t            take_slv;
  logic [2:0]                        busy;
  rd_order_pkg::err_flags_t          log_err;
  rd_order_pkg::err_flags_t          credit_err;
  rd_order_pkg::err_flags_t          check_err;
  rd_order_pkg::err_flags_t          flags;

  if (NumSlaves < 1 || NumSlaves > rd_order_pkg::MaxSlaves) begin : gen_bad_cfg
    $error("NumSlaves out of range");
  end

  assign flags = log_err | credit_err | check_err;

  ar_issue_log #(
    .NumSlaves (NumSlaves),
    .FifoDepth (FifoDepth)
  ) issue_log_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ar_i        (mst_ar_i),
    .pop_i       (pop),
    .pop_id_i    (pop_id),
    .head_o      (head),
    .log_empty_o (log_empty),
    .push_o      (push),
    .push_id_o   (push_id),
    .push_slv_o  (push_slv),
    .busy_o      (busy[0]),
    .err_o       (log_err)
  );

  slv_beat_credit #(
    .NumSlaves (NumSlaves),
    .FifoDepth (FifoDepth)
  ) beat_credit_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .push_i         (push),
    .push_id_i      (push_id),
    .push_slv_i     (push_slv),
    .slv_r_i        (slv_r_i),
    .take_i         (take),
    .take_id_i      (take_id),
    .take_slv_i     (take_slv),
    .credit_avail_o (credit_avail),
    .busy_o         (busy[1]),
    .err_o          (credit_err)
  );

  rsp_order_check #(
    .NumSlaves (NumSlaves)
  ) order_check_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .r_i            (mst_r_i),
    .head_i         (head),
    .log_empty_i    (log_empty),
    .credit_avail_i (credit_avail),
    .pop_o          (pop),
    .pop_id_o       (pop_id),
    .take_o         (take),
    .take_id_o      (take_id),
    .take_slv_o     (take_slv),
    .busy_o         (busy[2]),
    .err_o          (check_err)
  );

  order_check_ctrl #(
    .NumBusy (3)
  ) ctrl_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flags_i    (flags),
    .busy_i     (busy),
    .err_o      (err_o),
    .err_code_o (err_code_o),
    .idle_o     (idle_o)
  );

endmodule

`default_nettype wire

// ==== rtl/rd_order_pkg.sv ====
// shared widths, region map and beat types for the read-order monitor RTL and its testbench
`default_nettype none

package rd_order_pkg;

  localparam int unsigned IdWidth   = 2;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned NumIds    = 2 ** IdWidth;

  // region map, slave k owns [k*RegionSize, (k+1)*RegionSize)
  localparam int unsigned MaxSlaves   = 4;
  localparam int unsigned SlvIdxWidth = $clog2(MaxSlaves);
  localparam int unsigned RegionSize  = 4096;
  localparam int unsigned RegionBits  = $clog2(RegionSize);

  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [LenWidth-1:0]    len_t;
  typedef logic [SlvIdxWidth-1:0] slv_idx_t;

  // snooped read address channel
  typedef struct packed {
    logic                 valid;
    logic                 ready;
    id_t                  id;
    logic [AddrWidth-1:0] addr;
    len_t                 len;
  } ar_beat_t;

  // snooped read data channel, id not meaningful on slave ports
  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
    logic last;
  } r_beat_t;

  // one order-log entry
  typedef struct packed {
    slv_idx_t slv;
    len_t     len;
  } issue_t;

  // listed in priority order
  typedef enum logic [2:0] {
    ERR_NONE,
    ERR_DECODE,
    ERR_OVERFLOW,
    ERR_NO_ISSUE,
    ERR_ORDER,
    ERR_LEN,
    ERR_SLV_UNEXP
  } err_code_e;

  typedef struct packed {
    logic decode;
    logic overflow;
    logic no_issue;
    logic order;
    logic length;
    logic slv_unexp;
  } err_flags_t;

  typedef enum logic {
    ST_RUN,
    ST_FAIL
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/rsp_order_check.sv ====
// checks master-side read beats against the per-ID log heads, slave credits and burst lengths
`timescale 1ns/1ps
`default_nettype none

module rsp_order_check #(
  parameter int unsigned NumSlaves = 2
) (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  rd_order_pkg::r_beat_t                           r_i,
  input  rd_order_pkg::issue_t [rd_order_pkg::NumIds-1:0] head_i,
  input  logic [rd_order_pkg::NumIds-1:0]                 log_empty_i,
  input  logic [NumSlaves-1:0][rd_order_pkg::NumIds-1:0]  credit_avail_i,
  output logic                                            pop_o,
  output rd_order_pkg::id_t                               pop_id_o,
  output logic                                            take_o,
  output rd_order_pkg::id_t                               take_id_o,
  output rd_order_pkg::slv_idx_t                          take_slv_o,
  output logic                                            busy_o,
  output rd_order_pkg::err_flags_t                        err_o
);

  // beats already seen in the current burst of each ID
  rd_order_pkg::len_t [rd_order_pkg::NumIds-1:0] beat_cnt_q;

  rd_order_pkg::issue_t head;
  rd_order_pkg::len_t   cur_cnt;
  logic                 handshake;
  logic                 issued;
  logic                 has_credit;
  logic                 at_end;

  assign handshake  = r_i.valid & r_i.ready;
  assign head       = head_i[r_i.id];
  assign cur_cnt    = beat_cnt_q[r_i.id];
  assign issued     = !log_empty_i[r_i.id];
  assign has_credit = credit_avail_i[head.slv][r_i.id];
  assign at_end     = (cur_cnt == head.len);

  assign take_o     = handshake & issued & has_credit;
  assign take_id_o  = r_i.id;
  assign take_slv_o = head.slv;
  assign pop_o      = take_o & r_i.last;
  assign pop_id_o   = r_i.id;

  always_comb begin
    err_o          = '0;
    err_o.no_issue = handshake & ~issued;
    err_o.order    = handshake & issued & ~has_credit;
    // last early, or burst running past len+1
    err_o.length   = take_o & (r_i.last ^ at_end);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (take_o) begin
      if (r_i.last) begin
        beat_cnt_q[r_i.id] <= '0;
      end else begin
        beat_cnt_q[r_i.id] <= cur_cnt + 1'b1;
      end
    end
  end

  assign busy_o = |beat_cnt_q;

endmodule

`default_nettype wire

// ==== rtl/slv_beat_credit.sv ====
// per-slave ID tag queues and per-slave, per-ID credit counters fed by slave-side read beats
`timescale 1ns/1ps
`default_nettype none

module slv_beat_credit #(
  parameter int unsigned NumSlaves = 2,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                                                push_i,
  input  rd_order_pkg::id_t                                   push_id_i,
  input  rd_order_pkg::slv_idx_t                              push_slv_i,
  input  rd_order_pkg::r_beat_t [NumSlaves-1:0]               slv_r_i,
  input  logic                                                take_i,
  input  rd_order_pkg::id_t                                   take_id_i,
  input  rd_order_pkg::slv_idx_t                              take_slv_i,
  output logic [NumSlaves-1:0][rd_order_pkg::NumIds-1:0]      credit_avail_o,
  output logic                                                busy_o,
  output rd_order_pkg::err_flags_t                            err_o
);

  localparam int unsigned NumIds      = rd_order_pkg::NumIds;
  localparam int unsigned PtrWidth    = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth    = $clog2(FifoDepth + 1);
  // enough for FifoDepth full-length bursts
  localparam int unsigned CreditWidth = rd_order_pkg::LenWidth + PtrWidth + 1;

  typedef logic [PtrWidth-1:0]    ptr_t;
  typedef logic [CntWidth-1:0]    cnt_t;
  typedef logic [CreditWidth-1:0] credit_t;

  logic [NumSlaves-1:0] tag_busy;
  logic [NumSlaves-1:0] tag_ovf;
  logic [NumSlaves-1:0] unexp;

  function automatic ptr_t ptr_inc(input ptr_t ptr);
    return (ptr == ptr_t'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  for (genvar s = 0; s < NumSlaves; s++) begin : gen_slv
    rd_order_pkg::id_t tag_mem_q [FifoDepth];
    ptr_t              wr_ptr_q;
    ptr_t              rd_ptr_q;
    cnt_t              tag_cnt_q;
    rd_order_pkg::id_t head_id;
    logic              beat;
    logic              push_here;
    logic              push_ok;
    logic              pop_here;
    logic              has_tag;

    assign beat      = slv_r_i[s].valid & slv_r_i[s].ready;
    assign has_tag   = (tag_cnt_q != '0);
    assign push_here = push_i && (push_slv_i == rd_order_pkg::slv_idx_t'(s));
    assign push_ok   = push_here && (tag_cnt_q != cnt_t'(FifoDepth));
    // slave serves in arrival order, tag retires on last
    assign pop_here  = beat && slv_r_i[s].last && has_tag;
    assign head_id   = tag_mem_q[rd_ptr_q];

    assign unexp[s]    = beat && !has_tag;
    assign tag_ovf[s]  = push_here && !push_ok;
    assign tag_busy[s] = has_tag;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q  <= '0;
        rd_ptr_q  <= '0;
        tag_cnt_q <= '0;
      end else begin
        if (push_ok) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_here) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        tag_cnt_q <= tag_cnt_q + cnt_t'(push_ok) - cnt_t'(pop_here);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push_ok) begin
        tag_mem_q[wr_ptr_q] <= push_id_i;
      end
    end

    for (genvar i = 0; i < NumIds; i++) begin : gen_id
      credit_t credit_q;
      logic    inc;
      logic    dec;

      assign inc = beat && has_tag && (head_id == rd_order_pkg::id_t'(i));
      assign dec = take_i && (take_slv_i == rd_order_pkg::slv_idx_t'(s))
                   && (take_id_i == rd_order_pkg::id_t'(i));

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
          credit_q <= '0;
        end else begin
          credit_q <= credit_q + credit_t'(inc) - credit_t'(dec);
        end
      end

      assign credit_avail_o[s][i] = (credit_q != '0);

      a_credit_no_wrap: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) inc && !dec |=> credit_q != '0
      );
    end
  end

  always_comb begin
    err_o           = '0;
    err_o.overflow  = |tag_ovf;
    err_o.slv_unexp = |unexp;
  end

  assign busy_o = (|tag_busy) | (|credit_avail_o);

endmodule

`default_nettype wire
